/* side_ch_control.f */
+incdir+include
design/side_ch_cfg_pkg.sv
design/side_ch_stream_pkg.sv
design/iq_capture_engine.sv
design/csi_capture_engine.sv
design/dma_source_select.sv
design/side_ch_control.sv
test/tb_side_ch_control.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the side channel testbench with verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert \
	-f side_ch_control.f \
	--top-module tb_side_ch_control \
	-o tb_side_ch_control \
	&& ./obj_dir/tb_side_ch_control > sim.log 2>&1

[ -f sim.log ] && cat sim.log

grep -q "RESULT: FAIL" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"
exit 0

/* test/tb_side_ch_control.sv */
// testbench for the side channel top with loopback, auto start,
// iq frame, csi frame and room checks done by assertions
`timescale 1ns/1ps
`include "side_ch_consts.svh"

module tb_side_ch_control;
	import side_ch_cfg_pkg::*;
	import side_ch_stream_pkg::*;

	localparam int test_cycles = 2500; // rough length of all tests
	localparam int max_cycles = 8 * test_cycles;
	localparam int pre_len = 20;
	localparam int iq_len = 40;

	logic clk;
	logic rstn;
	rx_events_t rx_ev;
	tx_events_t tx_ev;
	logic [63:0] tsf_runtime_val;
	logic [31:0] iq0;
	logic [31:0] iq1;
	logic iq_strobe;
	logic demod_is_ongoing;
	logic [31:0] fc_di;
	logic fc_di_valid;
	logic [47:0] addr1;
	logic addr1_valid;
	logic [15:0] pkt_len;
	logic [31:0] csi;
	logic csi_valid;
	logic [31:0] phase_offset_taken;
	logic iq_capture;
	iq_cfg_t iq_cfg;
	csi_match_cfg_t csi_cfg;
	start_mode_e m_axis_start_mode;
	logic m_axis_start_ext_trigger;
	logic slv_reg_wren;
	logic [4:0] axi_awaddr_core;
	logic [63:0] data_to_pl;
	logic emptyn_to_pl;
	logic s_axis_tlast;
	logic pl_ask_data;
	logic [13:0] m_axis_data_count;
	logic m_axis_start_1trans;
	logic [63:0] data_to_ps;
	logic data_to_ps_valid;

	integer seed;
	int cycles;
	int start_cnt;
	logic [31:0] sample_cnt;
	logic [63:0] exp_q[$];
	logic [63:0] got_q[$];
	logic dma_write;
	logic dma_write_q;
	logic [1:0] first_write_q;
	logic exp_start;
	logic side_mode;

	side_ch_control dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic abort_sim(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_mismatch(input string msg);
		abort_sim($sformatf("[ERROR] %0t ns: %s", $time, msg));
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles)
			abort_sim($sformatf("timeout after %0d cycles, a frame never completed", cycles));
	end

	// start pulse comes two cycles after the first write cycle
	assign dma_write = slv_reg_wren && (axi_awaddr_core == 5'd2);

	always @(posedge clk) begin
		if (!rstn) begin
			dma_write_q <= 1'b0;
			first_write_q <= '0;
		end else begin
			dma_write_q <= dma_write;
			first_write_q <= {first_write_q[0], dma_write && !dma_write_q};
		end
	end
	assign exp_start = first_write_q[1];
	assign side_mode = (m_axis_start_mode == mode_auto) || (m_axis_start_mode == mode_ext);

	assert property (@(posedge clk) disable iff (!rstn)
		m_axis_start_mode != mode_loopback ||
		(data_to_ps == data_to_pl && data_to_ps_valid == emptyn_to_pl &&
		pl_ask_data && m_axis_start_1trans == s_axis_tlast))
		else report_mismatch("loopback outputs do not follow the s_axis side");

	assert property (@(posedge clk) disable iff (!rstn)
		m_axis_start_mode != mode_off ||
		(data_to_ps == '0 && !data_to_ps_valid && !pl_ask_data && !m_axis_start_1trans))
		else report_mismatch("outputs not quiet in off mode");

	assert property (@(posedge clk) disable iff (!rstn)
		m_axis_start_mode != mode_auto || m_axis_start_1trans == exp_start)
		else report_mismatch("auto start pulse at the wrong cycle");

	assert property (@(posedge clk) disable iff (!rstn)
		m_axis_start_mode != mode_ext || m_axis_start_1trans == m_axis_start_ext_trigger)
		else report_mismatch("ext start does not follow the external trigger");

	// side channel words, checked against the expected queue when it holds any
	always @(posedge clk) begin
		if (rstn && side_mode && data_to_ps_valid) begin
			if (exp_q.size() != 0) begin
				assert (data_to_ps == exp_q[0])
					else report_mismatch($sformatf("word %0d is %h, expected %h",
						got_q.size(), data_to_ps, exp_q[0]));
				exp_q.delete(0);
			end
			got_q.push_back(data_to_ps);
		end
		if (rstn && m_axis_start_mode == mode_auto && m_axis_start_1trans)
			start_cnt++;
	end

	// one clock with free running tsf and randomly gapped iq samples
	task automatic step();
		@(posedge clk);
		#1;
		tsf_runtime_val = tsf_runtime_val + 64'd1;
		iq_strobe = rstn && iq_capture && (($random(seed) & 3) != 0);
		if (iq_strobe) begin
			iq0 = sample_cnt;
			sample_cnt = sample_cnt + 32'd1;
		end
	endtask

	task automatic idle(input int n);
		repeat (n) step();
	endtask

	task automatic wait_words(input int n);
		while (got_q.size() < n)
			step();
	endtask

	task automatic write_reg(input logic [4:0] addr, input int len);
		slv_reg_wren = 1'b1;
		axi_awaddr_core = addr;
		idle(len);
		slv_reg_wren = 1'b0;
		axi_awaddr_core = 5'd0;
	endtask

	function automatic bit used_subcarrier(input int idx);
		return (idx >= 1 && idx <= 28) || (idx >= 36 && idx <= 63);
	endfunction

	// on air the first four address bytes come in reverse order
	function automatic logic [47:0] mac_from_target(input logic [31:0] t);
		return {t[7:0], t[15:8], t[23:16], t[31:24], 16'h5a3c};
	endfunction

	task automatic run_iq_frame(input trig_sel_e sel, input bit expect_frame);
		logic [63:0] ev_tsf;
		logic [31:0] ev_cnt;
		logic [31:0] first;
		int diff;
		iq_cfg.trigger_select = sel;
		idle(100); // fill the ring ahead of the trigger
		got_q.delete();
		rx_ev.fcs_strobe = 1'b1;
		rx_ev.fcs_ok = 1'b1;
		ev_tsf = tsf_runtime_val;
		ev_cnt = sample_cnt;
		step();
		rx_ev.fcs_strobe = 1'b0;
		rx_ev.fcs_ok = 1'b0;
		if (expect_frame) begin
			wait_words(iq_len + 1);
			idle(20);
			assert (got_q.size() == iq_len + 1)
				else report_mismatch($sformatf("iq frame has %0d words", got_q.size()));
			// tsf locked one cycle after the event is sampled
			assert (got_q[0] == ev_tsf + 64'd1)
				else report_mismatch($sformatf("iq header %h, expected %h",
					got_q[0], ev_tsf + 64'd1));
			first = got_q[1][31:0];
			diff = int'(first) - (int'(ev_cnt) - pre_len);
			assert (diff >= -2 && diff <= 2)
				else report_mismatch($sformatf("first iq sample %0d, trigger count %0d",
					first, ev_cnt));
			for (int k = 2; k <= iq_len; k++) begin
				assert (got_q[k][31:0] == first + 32'(k - 1))
					else report_mismatch($sformatf("iq sample %0d is %0d", k, got_q[k][31:0]));
			end
		end else begin
			idle(150);
			assert (got_q.size() == 0)
				else report_mismatch($sformatf("unexpected iq frame of %0d words",
					got_q.size()));
		end
	endtask

	task automatic run_csi_frame(input logic [15:0] fc, input bit expect_frame);
		logic [63:0] hdr_tsf;
		got_q.delete();
		exp_q.delete();
		step();
		demod_is_ongoing = 1'b1;
		rx_ev.hdr_strobe = 1'b1;
		hdr_tsf = tsf_runtime_val;
		if (expect_frame) begin
			exp_q.push_back(hdr_tsf);
			exp_q.push_back({32'd0, phase_offset_taken});
			for (int i = 0; i < `SC_CSI_ENTRIES; i++)
				if (used_subcarrier(i))
					exp_q.push_back({32'd0, 32'(i)});
		end
		step();
		rx_ev.hdr_strobe = 1'b0;
		pkt_len = 16'd20;
		fc_di = {16'd0, fc};
		fc_di_valid = 1'b1;
		step();
		addr1 = mac_from_target(csi_cfg.addr1_target);
		addr1_valid = 1'b1;
		for (int i = 0; i < `SC_CSI_ENTRIES; i++) begin
			step();
			csi = 32'(i);
			csi_valid = 1'b1;
		end
		step();
		csi_valid = 1'b0; // end of csi starts the frame
		if (expect_frame) begin
			wait_words(`SC_HEADER_LEN + `SC_CSI_LEN);
			idle(10);
		end else begin
			idle(120);
		end
		assert (got_q.size() == (expect_frame ? `SC_HEADER_LEN + `SC_CSI_LEN : 0))
			else report_mismatch($sformatf("csi frame has %0d words", got_q.size()));
		assert (exp_q.size() == 0)
			else report_mismatch($sformatf("%0d csi words missing", exp_q.size()));
		demod_is_ongoing = 1'b0;
		fc_di_valid = 1'b0;
		addr1_valid = 1'b0;
		idle(4);
	endtask

	initial begin
		seed = 91723;
		cycles = 0;
		start_cnt = 0;
		sample_cnt = '0;
		rstn = 1'b0;
		rx_ev = '0;
		tx_ev = '0;
		tsf_runtime_val = 64'h0000_1000_0000_0000;
		iq0 = '0;
		iq1 = '0;
		iq_strobe = 1'b0;
		demod_is_ongoing = 1'b0;
		fc_di = '0;
		fc_di_valid = 1'b0;
		addr1 = '0;
		addr1_valid = 1'b0;
		pkt_len = '0;
		csi = '0;
		csi_valid = 1'b0;
		phase_offset_taken = 32'h0000_3a7c;
		iq_capture = 1'b1;
		iq_cfg = '0;
		iq_cfg.trigger_select = trig_fcs_ok;
		iq_cfg.pre_trigger_len = 14'(pre_len);
		iq_cfg.iq_len_target = 14'(iq_len);
		csi_cfg.fc_target = 16'h0088; // qos data
		csi_cfg.addr1_target = 32'hc0ff_ee42;
		csi_cfg.fc_match_en = 1'b1;
		csi_cfg.addr1_match_en = 1'b1;
		m_axis_start_mode = mode_loopback;
		m_axis_start_ext_trigger = 1'b0;
		slv_reg_wren = 1'b0;
		axi_awaddr_core = '0;
		data_to_pl = '0;
		emptyn_to_pl = 1'b0;
		s_axis_tlast = 1'b0;
		m_axis_data_count = '0;
		idle(4);
		rstn = 1'b1;

		repeat (32) begin
			step();
			data_to_pl = {$random(seed), $random(seed)};
			emptyn_to_pl = 1'($random(seed));
			s_axis_tlast = 1'($random(seed));
		end
		m_axis_start_mode = mode_off;
		idle(16);
		data_to_pl = '0;
		emptyn_to_pl = 1'b0;
		s_axis_tlast = 1'b0;

		m_axis_start_mode = mode_auto;
		idle(4);
		start_cnt = 0;
		write_reg(5'd2, 2);
		idle(6);
		assert (start_cnt == 1)
			else report_mismatch($sformatf("%0d start pulses after dma count write", start_cnt));
		start_cnt = 0;
		write_reg(5'd5, 1);
		write_reg(5'd0, 2);
		idle(6);
		assert (start_cnt == 0)
			else report_mismatch($sformatf("%0d start pulses after other writes", start_cnt));

		m_axis_start_mode = mode_ext;
		repeat (12) begin
			step();
			m_axis_start_ext_trigger = 1'($random(seed));
		end
		m_axis_start_ext_trigger = 1'b0;

		m_axis_start_mode = mode_auto;
		run_iq_frame(trig_fcs_ok, 1'b1);
		run_iq_frame(trig_fcs_bad, 1'b0);
		m_axis_data_count = 14'(`SC_MAX_UDP_SYMBOLS - iq_len);
		run_iq_frame(trig_fcs_ok, 1'b0);
		m_axis_data_count = '0;

		iq_capture = 1'b0;
		idle(4);
		run_csi_frame(16'h0088, 1'b1);
		run_csi_frame(16'h0208, 1'b0);
		// one word short of a whole csi frame
		m_axis_data_count = 14'(`SC_MAX_UDP_SYMBOLS - (`SC_HEADER_LEN + `SC_CSI_LEN) + 1);
		run_csi_frame(16'h0088, 1'b0);
		m_axis_data_count = '0;
		idle(4);

		$display("RESULT: PASS");
		$finish;
	end

endmodule

/* design/side_ch_control.sv */
// side channel top: iq and csi engines feeding the dma source selector
`timescale 1ns/1ps
`include "side_ch_consts.svh"

module side_ch_control (
	input logic clk,
	input logic rstn,
	input side_ch_stream_pkg::rx_events_t rx_ev,
	input side_ch_stream_pkg::tx_events_t tx_ev,
	input logic [`SC_TSF_W-1:0] tsf_runtime_val,
	input logic [2*`SC_IQ_W-1:0] iq0,
	input logic [2*`SC_IQ_W-1:0] iq1,
	input logic iq_strobe,
	input logic demod_is_ongoing,
	input logic [31:0] fc_di,
	input logic fc_di_valid,
	input logic [47:0] addr1,
	input logic addr1_valid,
	input logic [15:0] pkt_len,
	input logic [2*`SC_IQ_W-1:0] csi,
	input logic csi_valid,
	input logic [31:0] phase_offset_taken,
	input logic iq_capture,
	input side_ch_cfg_pkg::iq_cfg_t iq_cfg,
	input side_ch_cfg_pkg::csi_match_cfg_t csi_cfg,
	input side_ch_cfg_pkg::start_mode_e m_axis_start_mode,
	input logic m_axis_start_ext_trigger,
	input logic slv_reg_wren,
	input logic [4:0] axi_awaddr_core,
	input logic [`SC_WORD_W-1:0] data_to_pl,
	input logic emptyn_to_pl,
	input logic s_axis_tlast,
	output logic pl_ask_data,
	input logic [`SC_LEN_W-1:0] m_axis_data_count,
	output logic m_axis_start_1trans,
	output logic [`SC_WORD_W-1:0] data_to_ps,
	output logic data_to_ps_valid
);
	import side_ch_stream_pkg::*;

	side_word_t iq_word;
	side_word_t csi_word;

	iq_capture_engine iq_eng0 (
		.clk (clk),
		.rstn (rstn),
		.enable (iq_capture),
		.cfg (iq_cfg),
		.rx_ev (rx_ev),
		.tx_ev (tx_ev),
		.tsf (tsf_runtime_val),
		.iq0 (iq0),
		.iq1 (iq1),
		.iq_strobe (iq_strobe),
		.room (m_axis_data_count),
		.word_out (iq_word)
	);

	csi_capture_engine csi_eng0 (
		.clk (clk),
		.rstn (rstn),
		.enable (!iq_capture), // csi runs when iq capture is off
		.cfg (csi_cfg),
		.rx_ev (rx_ev),
		.tsf (tsf_runtime_val),
		.demod_is_ongoing (demod_is_ongoing),
		.fc_di (fc_di),
		.fc_di_valid (fc_di_valid),
		.addr1 (addr1),
		.addr1_valid (addr1_valid),
		.pkt_len (pkt_len),
		.csi (csi),
		.csi_valid (csi_valid),
		.phase_offset_taken (phase_offset_taken),
		.room (m_axis_data_count),
		.word_out (csi_word)
	);

	dma_source_select sel0 (
		.clk (clk),
		.rstn (rstn),
		.mode (m_axis_start_mode),
		.ext_trigger (m_axis_start_ext_trigger),
		.slv_reg_wren (slv_reg_wren),
		.axi_awaddr_core (axi_awaddr_core),
		.iq_word (iq_word),
		.csi_word (csi_word),
		.data_to_pl (data_to_pl),
		.emptyn_to_pl (emptyn_to_pl),
		.s_axis_tlast (s_axis_tlast),
		.pl_ask_data (pl_ask_data),
		.m_axis_start_1trans (m_axis_start_1trans),
		.data_to_ps (data_to_ps),
		.data_to_ps_valid (data_to_ps_valid)
	);

endmodule

/* design/dma_source_select.sv */
// dma source selection: loopback, side channel with auto or ext start
`timescale 1ns/1ps
`include "side_ch_consts.svh"

module dma_source_select (
	input logic clk,
	input logic rstn,
	input side_ch_cfg_pkg::start_mode_e mode,
	input logic ext_trigger,
	input logic slv_reg_wren,
	input logic [4:0] axi_awaddr_core,
	input side_ch_stream_pkg::side_word_t iq_word,
	input side_ch_stream_pkg::side_word_t csi_word,
	input logic [`SC_WORD_W-1:0] data_to_pl,
	input logic emptyn_to_pl,
	input logic s_axis_tlast,
	output logic pl_ask_data,
	output logic m_axis_start_1trans,
	output logic [`SC_WORD_W-1:0] data_to_ps,
	output logic data_to_ps_valid
);
	import side_ch_cfg_pkg::*;

	logic wr_hit;
	logic [2:0] wr_q;
	logic auto_start;
	logic [`SC_WORD_W-1:0] side_data;
	logic side_valid;

	assign wr_hit = slv_reg_wren && (axi_awaddr_core == 5'(`SC_REG_NUM_DMA_SYMBOL));

	always_ff @(posedge clk) begin
		if (!rstn)
			wr_q <= '0;
		else
			wr_q <= {wr_q[1:0], wr_hit};
	end

	// first write cycle, seen two cycles late
	assign auto_start = wr_q[1] && !wr_q[2];

	// engines never drive valid at the same time
	assign side_data = iq_word.valid ? iq_word.data : csi_word.data;
	assign side_valid = iq_word.valid || csi_word.valid;

	always_comb begin
		case (mode)
			mode_loopback: begin
				m_axis_start_1trans = s_axis_tlast;
				data_to_ps = data_to_pl;
				data_to_ps_valid = emptyn_to_pl;
				pl_ask_data = 1'b1;
			end
			mode_auto: begin
				m_axis_start_1trans = auto_start;
				data_to_ps = side_data;
				data_to_ps_valid = side_valid;
				pl_ask_data = 1'b0;
			end
			mode_ext: begin
				m_axis_start_1trans = ext_trigger;
				data_to_ps = side_data;
				data_to_ps_valid = side_valid;
				pl_ask_data = 1'b0;
			end
			default: begin
				m_axis_start_1trans = 1'b0;
				data_to_ps = '0;
				data_to_ps_valid = 1'b0;
				pl_ask_data = 1'b0;
			end
		endcase
	end

endmodule

/* design/csi_capture_engine.sv */
// csi capture engine: frame matcher, 64 entry csi buffer
// and tsf / phase offset / subcarrier frame sequencer
`timescale 1ns/1ps
`include "side_ch_consts.svh"

module csi_capture_engine (
	input logic clk,
	input logic rstn,
	input logic enable,
	input side_ch_cfg_pkg::csi_match_cfg_t cfg,
	input side_ch_stream_pkg::rx_events_t rx_ev,
	input logic [`SC_TSF_W-1:0] tsf,
	input logic demod_is_ongoing,
	input logic [31:0] fc_di,
	input logic fc_di_valid,
	input logic [47:0] addr1,
	input logic addr1_valid,
	input logic [15:0] pkt_len,
	input logic [2*`SC_IQ_W-1:0] csi,
	input logic csi_valid,
	input logic [31:0] phase_offset_taken,
	input logic [`SC_LEN_W-1:0] room,
	output side_ch_stream_pkg::side_word_t word_out
);
	import side_ch_stream_pkg::*;

	localparam int aw = $clog2(`SC_CSI_ENTRIES);
	localparam int max_udp = `SC_MAX_UDP_SYMBOLS;
	localparam int frame_len = `SC_HEADER_LEN + `SC_CSI_LEN;
	localparam logic [`SC_CSI_ENTRIES-1:0] sc_mask = `SC_SUBCARRIER_MASK;

	logic [2*`SC_IQ_W-1:0] csi_ram [0:`SC_CSI_ENTRIES-1];
	logic [aw:0] wr_cnt; // msb set means buffer full
	logic [aw-1:0] rd_idx;

	logic demod_q;
	logic fc_valid_q;
	logic addr1_valid_q;
	logic csi_valid_q;
	logic demod_start;
	logic fc_hit;
	logic addr1_hit;
	logic csi_done;
	logic room_ok;
	logic [31:0] addr1_swapped;

	csi_state_e state;
	logic [`SC_TSF_W-1:0] tsf_lock;

	assign demod_start = demod_is_ongoing && !demod_q;
	assign csi_done = csi_valid_q && !csi_valid;

	// addr1 arrives byte reversed relative to the register
	assign addr1_swapped = {addr1[23:16], addr1[31:24], addr1[39:32], addr1[47:40]};

	assign fc_hit = fc_di_valid && !fc_valid_q && (pkt_len >= 16'd14) &&
		(fc_di[15:0] == cfg.fc_target || !cfg.fc_match_en);
	assign addr1_hit = addr1_valid && !addr1_valid_q &&
		(addr1_swapped == cfg.addr1_target || !cfg.addr1_match_en);

	assign room_ok = (max_udp - int'(room)) >= frame_len;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			demod_q <= 1'b0;
			fc_valid_q <= 1'b0;
			addr1_valid_q <= 1'b0;
			csi_valid_q <= 1'b0;
			wr_cnt <= '0;
		end else begin
			demod_q <= demod_is_ongoing;
			fc_valid_q <= fc_di_valid;
			addr1_valid_q <= addr1_valid;
			csi_valid_q <= csi_valid;
			if (!enable || demod_start)
				wr_cnt <= '0; // new packet, buffer starts empty
			else if (csi_valid && !wr_cnt[aw])
				wr_cnt <= wr_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= csi_wait_fc;
			rd_idx <= '0;
			word_out.valid <= 1'b0;
		end else if (!enable) begin
			state <= csi_wait_fc;
			rd_idx <= '0;
			word_out.valid <= 1'b0;
		end else begin
			case (state)
				csi_wait_fc: begin
					word_out.valid <= 1'b0;
					if (fc_hit)
						state <= csi_wait_addr1;
				end
				csi_wait_addr1: begin
					if (addr1_hit)
						state <= csi_wait_csi_done;
				end
				csi_wait_csi_done: begin
					if (csi_done)
						state <= csi_prepare;
				end
				csi_prepare: begin
					rd_idx <= '0;
					state <= room_ok ? csi_header0 : csi_wait_fc;
				end
				csi_header0: begin
					word_out.valid <= 1'b1;
					state <= csi_header1;
				end
				csi_header1: begin
					word_out.valid <= 1'b1;
					state <= csi_stream;
				end
				default: begin
					word_out.valid <= sc_mask[rd_idx]; // skip dc and guard bins
					rd_idx <= rd_idx + 1'b1;
					if (rd_idx == aw'(`SC_CSI_ENTRIES - 1))
						state <= csi_wait_fc;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (enable && csi_valid && !wr_cnt[aw])
			csi_ram[wr_cnt[aw-1:0]] <= csi;
		if (enable && rx_ev.hdr_strobe)
			tsf_lock <= tsf;
		case (state)
			csi_header0: word_out.data <= tsf_lock;
			csi_header1: word_out.data <= {32'd0, phase_offset_taken};
			csi_stream: word_out.data <= {32'd0, csi_ram[rd_idx]};
			default: word_out.data <= word_out.data;
		endcase
	end

endmodule

/* design/iq_capture_engine.sv */
// iq capture engine: ring buffer, trigger selection
// and header plus sample frame sequencer
`timescale 1ns/1ps
`include "side_ch_consts.svh"

module iq_capture_engine (
	input logic clk,
	input logic rstn,
	input logic enable,
	input side_ch_cfg_pkg::iq_cfg_t cfg,
	input side_ch_stream_pkg::rx_events_t rx_ev,
	input side_ch_stream_pkg::tx_events_t tx_ev,
	input logic [`SC_TSF_W-1:0] tsf,
	input logic [2*`SC_IQ_W-1:0] iq0,
	input logic [2*`SC_IQ_W-1:0] iq1,
	input logic iq_strobe,
	input logic [`SC_LEN_W-1:0] room,
	output side_ch_stream_pkg::side_word_t word_out
);
	import side_ch_cfg_pkg::*;
	import side_ch_stream_pkg::*;

	localparam int aw = `SC_IQ_DEPTH_LOG2;
	localparam int max_udp = `SC_MAX_UDP_SYMBOLS;

	logic [`SC_WORD_W-1:0] iq_ram [0:(1<<aw)-1];
	logic [`SC_WORD_W-1:0] wr_data;
	logic [`SC_WORD_W-1:0] rd_data;
	logic [aw-1:0] waddr;
	logic [aw-1:0] raddr;
	logic [aw-1:0] raddr_nxt;

	logic signed [10:0] rssi_q;
	logic [7:0] gpio_q;
	logic tx_bb_q;
	logic rssi_up, rssi_down;
	logic agc_unlock, agc_lock;
	logic gain_up, gain_down;
	logic tx_start, tx_end;
	logic trig_hit;
	logic trigger;

	iq_state_e state;
	logic [`SC_LEN_W-1:0] count;
	logic [`SC_TSF_W-1:0] tsf_lock;
	logic room_ok;
	logic last_sample;

	assign wr_data = cfg.iq_format ? {iq1, iq0} :
		{5'd0, rx_ev.rssi_half_db, 8'd0, rx_ev.gpio_status, iq0};

	// threshold crossings against the previous cycle
	assign rssi_up = ($signed(rssi_q) < $signed(cfg.rssi_th)) &&
		($signed(rx_ev.rssi_half_db) >= $signed(cfg.rssi_th));
	assign rssi_down = ($signed(rssi_q) >= $signed(cfg.rssi_th)) &&
		($signed(rx_ev.rssi_half_db) < $signed(cfg.rssi_th));
	assign agc_unlock = gpio_q[7] && !rx_ev.gpio_status[7];
	assign agc_lock = !gpio_q[7] && rx_ev.gpio_status[7];
	assign gain_up = (gpio_q[6:0] < cfg.gain_th) && (rx_ev.gpio_status[6:0] >= cfg.gain_th);
	assign gain_down = (gpio_q[6:0] >= cfg.gain_th) && (rx_ev.gpio_status[6:0] < cfg.gain_th);
	assign tx_start = tx_ev.tx_bb_ongoing && !tx_bb_q;
	assign tx_end = !tx_ev.tx_bb_ongoing && tx_bb_q;

	always_comb begin
		case (cfg.trigger_select)
			trig_fcs_any: trig_hit = rx_ev.fcs_strobe;
			trig_fcs_ok: trig_hit = rx_ev.fcs_strobe && rx_ev.fcs_ok;
			trig_fcs_bad: trig_hit = rx_ev.fcs_strobe && !rx_ev.fcs_ok;
			trig_hdr_any: trig_hit = rx_ev.hdr_strobe;
			trig_hdr_valid: trig_hit = rx_ev.hdr_strobe && rx_ev.hdr_valid;
			trig_hdr_invalid: trig_hit = rx_ev.hdr_strobe && !rx_ev.hdr_valid;
			trig_long_pre: trig_hit = rx_ev.long_pre;
			trig_short_pre: trig_hit = rx_ev.short_pre;
			trig_rssi_up: trig_hit = rssi_up;
			trig_rssi_down: trig_hit = rssi_down;
			trig_agc_unlock: trig_hit = agc_unlock;
			trig_agc_lock: trig_hit = agc_lock;
			trig_gain_up: trig_hit = gain_up;
			trig_gain_down: trig_hit = gain_down;
			trig_tx_bb_start: trig_hit = tx_start;
			default: trig_hit = tx_end;
		endcase
	end

	// dma fifo must take header plus all samples
	assign room_ok = (max_udp - int'(room)) >= (int'(cfg.iq_len_target) + 1);
	assign last_sample = (count == cfg.iq_len_target - 1'b1);

	// look ahead so rd_data always matches raddr
	always_comb begin
		raddr_nxt = raddr;
		if (state == iq_wait && trigger)
			raddr_nxt = waddr - cfg.pre_trigger_len[aw-1:0];
		else if (state == iq_stream && iq_strobe)
			raddr_nxt = raddr + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (enable && iq_strobe)
			iq_ram[waddr] <= wr_data;
		rd_data <= iq_ram[raddr_nxt];
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			waddr <= '0;
			raddr <= '0;
			rssi_q <= '0;
			gpio_q <= '0;
			tx_bb_q <= 1'b0;
			trigger <= 1'b0;
		end else begin
			if (enable && iq_strobe)
				waddr <= waddr + 1'b1;
			raddr <= raddr_nxt;
			rssi_q <= rx_ev.rssi_half_db;
			gpio_q <= rx_ev.gpio_status;
			tx_bb_q <= tx_ev.tx_bb_ongoing;
			trigger <= enable && trig_hit;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= iq_wait;
			count <= '0;
			word_out.valid <= 1'b0;
		end else if (!enable) begin
			state <= iq_wait; // idle while csi runs
			count <= '0;
			word_out.valid <= 1'b0;
		end else begin
			case (state)
				iq_wait: begin
					word_out.valid <= 1'b0;
					count <= '0;
					if (trigger)
						state <= iq_prepare;
				end
				iq_prepare: begin
					state <= room_ok ? iq_header : iq_wait;
				end
				iq_header: begin
					word_out.valid <= 1'b1;
					state <= (cfg.iq_len_target == '0) ? iq_wait : iq_stream;
				end
				default: begin
					word_out.valid <= iq_strobe;
					if (iq_strobe) begin
						count <= count + 1'b1;
						if (last_sample)
							state <= iq_wait;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == iq_wait && trigger)
			tsf_lock <= tsf;
		if (state == iq_header)
			word_out.data <= tsf_lock;
		else if (state == iq_stream)
			word_out.data <= rd_data;
	end

endmodule

/* design/side_ch_stream_pkg.sv */
// phy side event structs, stream word and engine states
`include "side_ch_consts.svh"

package side_ch_stream_pkg;

	typedef struct packed {
		logic fcs_strobe;
		logic fcs_ok;
		logic hdr_strobe;
		logic hdr_valid;
		logic ht_flag;
		logic long_pre;
		logic short_pre;
		logic signed [10:0] rssi_half_db;
		logic [7:0] gpio_status; // bit 7 agc lock, rest gain
	} rx_events_t;

	typedef struct packed {
		logic tx_bb_ongoing;
	} tx_events_t;

	typedef struct packed {
		logic [`SC_WORD_W-1:0] data;
		logic valid;
	} side_word_t;

	typedef enum logic [1:0] {
		iq_wait,
		iq_prepare,
		iq_header,
		iq_stream
	} iq_state_e;

	typedef enum logic [2:0] {
		csi_wait_fc,
		csi_wait_addr1,
		csi_wait_csi_done,
		csi_prepare,
		csi_header0,
		csi_header1,
		csi_stream
	} csi_state_e;

endpackage

/* design/side_ch_cfg_pkg.sv */
// processor side configuration types
// trigger choice, dma start mode, iq and csi capture config
`include "side_ch_consts.svh"

package side_ch_cfg_pkg;

	typedef enum logic [3:0] {
		trig_fcs_any,
		trig_fcs_ok,
		trig_fcs_bad,
		trig_hdr_any,
		trig_hdr_valid,
		trig_hdr_invalid,
		trig_long_pre,
		trig_short_pre,
		trig_rssi_up,
		trig_rssi_down,
		trig_agc_unlock,
		trig_agc_lock,
		trig_gain_up,
		trig_gain_down,
		trig_tx_bb_start,
		trig_tx_bb_end
	} trig_sel_e;

	typedef enum logic [1:0] {
		mode_loopback, // s_axis straight back to m_axis
		mode_auto,
		mode_ext,
		mode_off
	} start_mode_e;

	typedef struct packed {
		trig_sel_e trigger_select;
		logic signed [10:0] rssi_th; // half db
		logic [6:0] gain_th;
		logic [`SC_LEN_W-1:0] pre_trigger_len;
		logic [`SC_LEN_W-1:0] iq_len_target;
		logic iq_format; // 0: rssi/gpio/iq0, 1: iq1/iq0
	} iq_cfg_t;

	typedef struct packed {
		logic [15:0] fc_target;
		logic [31:0] addr1_target;
		logic fc_match_en;
		logic addr1_match_en;
	} csi_match_cfg_t;

endpackage

/* include/side_ch_consts.svh */
// widths, depths and frame constants of the side channel
`ifndef SIDE_CH_CONSTS_SVH
`define SIDE_CH_CONSTS_SVH

// sample and stream widths
`define SC_IQ_W 16
`define SC_WORD_W 64
`define SC_TSF_W 64
`define SC_LEN_W 14

// iq ring buffer address bits
`define SC_IQ_DEPTH_LOG2 13

// 65507 byte udp payload / 8
`define SC_MAX_UDP_SYMBOLS 8188

// csi frame layout
`define SC_CSI_ENTRIES 64
`define SC_CSI_LEN 56
`define SC_HEADER_LEN 2

// ht used subcarriers, bit 0 is dc
// bits 1..28 positive side, 36..63 negative side
`define SC_SUBCARRIER_MASK 64'hFFFF_FFF0_1FFF_FFFE

// slave register holding the dma symbol count
`define SC_REG_NUM_DMA_SYMBOL 2

`endif
